// ==== Bender.yml ====
package:
  name: adc_spi

sources:
  - include_dirs:
      - src
    files:
      - src/adc_spi_pkg.sv
      - src/spi_ctrl_if.sv
      - src/spi_sequencer.sv
      - src/sck_timer.sv
      - src/lane_deserializer.sv
      - src/cfg_serializer.sv
      - src/adc_wb_regs.sv
      - src/adc_spi_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/adc4630_bfm.sv
      - verification/tb_adc_spi.sv

// ==== list.f ====
+incdir+src
src/adc_spi_pkg.sv
src/spi_ctrl_if.sv
src/spi_sequencer.sv
src/sck_timer.sv
src/lane_deserializer.sv
src/cfg_serializer.sv
src/adc_wb_regs.sv
src/adc_spi_top.sv
verification/adc4630_bfm.sv
verification/tb_adc_spi.sv

// ==== src/adc_spi_defs.svh ====
`ifndef ADC_SPI_DEFS_SVH
`define ADC_SPI_DEFS_SVH

// lane geometry of one read frame
`define ADC_LANES 4
`define LANE_BITS 6

// config word width, also the SCK count of a config frame
`define CFG_BITS 24

// SCK half periods in i_clk cycles
`define READ_HALF 2
`define CFG_HALF 3

// chip-select framing delays in i_clk cycles
`define CS_LEAD 4
`define CS_LAG 3

// Wishbone word addresses
`define REG_CTRL 3'd0
`define REG_CFG 3'd1
`define REG_STATUS 3'd2
`define REG_SAMPLE 3'd3
`define REG_COUNT 3'd4

`endif

// ==== src/adc_spi_pkg.sv ====
package adc_spi_pkg;

	`include "adc_spi_defs.svh"

	// frame sequencer states
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		LEAD  = 3'd1,
		SHIFT = 3'd2,
		LAG   = 3'd3,
		DONE  = 3'd4
	} seq_state_e;

	// read frames use SPI mode 00, config frames use mode 01
	typedef enum logic {
		MODE_READ = 1'b0,
		MODE_CFG  = 1'b1
	} spi_mode_e;

	// lane k fills bits 6k+5 down to 6k
	typedef logic [`ADC_LANES*`LANE_BITS-1:0] sample_t;

	// shifted out msb first
	typedef logic [`CFG_BITS-1:0] cfg_word_t;

endpackage

// ==== src/adc_spi_top.sv ====
`timescale 1ns/100ps

`include "adc_spi_defs.svh"

module adc_spi_top (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_wb_we,
	input  logic [2:0] i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic o_wb_ack,
	output logic o_cs_n,
	output logic o_sck,
	output logic o_mosi,
	output logic o_mosi_oe,
	input  logic [`ADC_LANES-1:0] i_miso
);

	import adc_spi_pkg::*;

	logic start;
	logic busy;
	spi_mode_e mode;
	cfg_word_t cfg;
	sample_t sample;
	logic sample_stb;

	spi_ctrl_if u_ctrl ();

	adc_wb_regs u_regs (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.i_busy(busy),
		.i_sample(sample),
		.i_sample_stb(sample_stb),
		.o_start(start),
		.o_mode(mode),
		.o_cfg(cfg)
	);

	spi_sequencer u_seq (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_start(start),
		.i_mode(mode),
		.o_busy(busy),
		.o_cs_n(o_cs_n),
		.ctrl(u_ctrl.seq)
	);

	sck_timer u_timer (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.ctrl(u_ctrl.timer)
	);

	lane_deserializer u_rx (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_miso(i_miso),
		.ctrl(u_ctrl.rx),
		.o_sample(sample),
		.o_sample_stb(sample_stb)
	);

	cfg_serializer u_tx (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_cfg(cfg),
		.ctrl(u_ctrl.tx),
		.o_mosi(o_mosi),
		.o_mosi_oe(o_mosi_oe)
	);

	assign o_sck = u_ctrl.sck; // SCK comes straight from the timer register

endmodule

// ==== src/adc_wb_regs.sv ====
`timescale 1ns/100ps

`include "adc_spi_defs.svh"

module adc_wb_regs (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_wb_we,
	input  logic [2:0] i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic o_wb_ack,
	input  logic i_busy,
	input  adc_spi_pkg::sample_t i_sample,
	input  logic i_sample_stb,
	output logic o_start,
	output adc_spi_pkg::spi_mode_e o_mode,
	output adc_spi_pkg::cfg_word_t o_cfg
);

	import adc_spi_pkg::*;

	logic req;
	logic wr_req;
	logic rd_req;
	logic start_req;
	logic valid_q;
	logic overrun_q;
	sample_t sample_q;
	logic [15:0] count_q;
	logic [31:0] rd_data;

	assign req = i_wb_cyc && i_wb_stb && !o_wb_ack; // ack closes the cycle after one clock
	assign wr_req = req && i_wb_we;
	assign rd_req = req && !i_wb_we;
	assign start_req = wr_req && (i_wb_adr == `REG_CTRL) && (i_wb_dat[1:0] != 2'b00) && !i_busy;

	always_comb
	begin
		case (i_wb_adr)
			`REG_CFG: rd_data = 32'(o_cfg);
			`REG_STATUS: rd_data = {29'd0, overrun_q, valid_q, i_busy};
			`REG_SAMPLE: rd_data = 32'(sample_q);
			`REG_COUNT: rd_data = {16'd0, count_q};
			default: rd_data = 32'd0; // CTRL is write only
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_wb_ack <= 1'b0;
			o_wb_dat <= 32'd0;
			o_start <= 1'b0;
			o_mode <= MODE_READ;
			valid_q <= 1'b0;
			overrun_q <= 1'b0;
			count_q <= 16'd0;
		end
		else
		begin
			o_wb_ack <= req;
			if (rd_req)
				o_wb_dat <= rd_data;
			o_start <= start_req; // lines up with the ack clock
			if (start_req)
				o_mode <= i_wb_dat[1] ? MODE_CFG : MODE_READ; // config wins if both bits are set
			if (i_sample_stb)
				valid_q <= 1'b1; // a new sample beats a read in the same clock
			else if (rd_req && (i_wb_adr == `REG_SAMPLE))
				valid_q <= 1'b0;
			if (i_sample_stb && valid_q)
				overrun_q <= 1'b1;
			else if (rd_req && (i_wb_adr == `REG_STATUS))
				overrun_q <= 1'b0;
			if (i_sample_stb)
				count_q <= count_q + 16'd1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (wr_req && (i_wb_adr == `REG_CFG))
			o_cfg <= i_wb_dat[`CFG_BITS-1:0];
		if (i_sample_stb)
			sample_q <= i_sample; // an unread sample is overwritten
	end

endmodule

// ==== src/cfg_serializer.sv ====
`timescale 1ns/100ps

`include "adc_spi_defs.svh"

module cfg_serializer (
	input  logic i_clk,
	input  logic i_rst,
	input  adc_spi_pkg::cfg_word_t i_cfg,
	spi_ctrl_if.tx ctrl,
	output logic o_mosi,
	output logic o_mosi_oe
);

	import adc_spi_pkg::*;

	cfg_word_t shift_q;
	logic first_q; // msb already on the line, so the first rise keeps it
	logic oe_q;

	always_ff @(posedge i_clk)
	begin
		if (ctrl.load)
			shift_q <= i_cfg;
		else if (ctrl.sck_rise && !first_q)
			shift_q <= {shift_q[`CFG_BITS-2:0], 1'b0};
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			first_q <= 1'b0;
			oe_q <= 1'b0;
		end
		else
		begin
			if (ctrl.load)
				first_q <= 1'b1;
			else if (ctrl.sck_rise)
				first_q <= 1'b0;
			if (ctrl.load)
				oe_q <= (ctrl.mode == MODE_CFG); // read frames leave MOSI undriven
			else if (ctrl.capture)
				oe_q <= 1'b0;
		end
	end

	assign o_mosi = oe_q && shift_q[`CFG_BITS-1];
	assign o_mosi_oe = oe_q;

endmodule

// ==== src/lane_deserializer.sv ====
`timescale 1ns/100ps

`include "adc_spi_defs.svh"

module lane_deserializer (
	input  logic i_clk,
	input  logic i_rst,
	input  logic [`ADC_LANES-1:0] i_miso,
	spi_ctrl_if.rx ctrl,
	output adc_spi_pkg::sample_t o_sample,
	output logic o_sample_stb
);

	import adc_spi_pkg::*;

	logic [`LANE_BITS-1:0] lane_sr [`ADC_LANES];

	// mode 00 data is stable on the rising SCK edge
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			for (int k = 0; k < `ADC_LANES; k++)
				lane_sr[k] <= '0;
		end
		else if (ctrl.sck_rise)
		begin
			for (int k = 0; k < `ADC_LANES; k++)
				lane_sr[k] <= {lane_sr[k][`LANE_BITS-2:0], i_miso[k]}; // msb arrives first
		end
	end

	// lane k owns the k-th slice of the sample
	always_comb
	begin
		for (int k = 0; k < `ADC_LANES; k++)
			o_sample[k*`LANE_BITS +: `LANE_BITS] = lane_sr[k];
	end

	// config frames clock MISO too, but their data is not a sample
	assign o_sample_stb = ctrl.capture && (ctrl.mode == MODE_READ);

endmodule

// ==== src/sck_timer.sv ====
`timescale 1ns/100ps

`include "adc_spi_defs.svh"

module sck_timer (
	input  logic i_clk,
	input  logic i_rst,
	spi_ctrl_if.timer ctrl
);

	import adc_spi_pkg::*;

	logic [2:0] half_cnt;
	logic [2:0] half_max;
	logic [4:0] bit_cnt; // falling edges seen in this frame
	logic [4:0] bit_max;
	logic sck_q;
	logic tick;
	logic rise_tick;
	logic fall_tick;
	logic done_q;

	assign half_max = (ctrl.mode == MODE_CFG) ? 3'(`CFG_HALF - 1) : 3'(`READ_HALF - 1);
	assign bit_max = (ctrl.mode == MODE_CFG) ? 5'(`CFG_BITS - 1) : 5'(`LANE_BITS - 1);

	// no more toggles once every bit has had its falling edge
	assign tick = ctrl.run && (bit_cnt <= bit_max) && (half_cnt == half_max);
	assign rise_tick = tick && !sck_q;
	assign fall_tick = tick && sck_q;

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			half_cnt <= 3'd0;
			bit_cnt <= 5'd0;
			sck_q <= 1'b0;
			done_q <= 1'b0;
		end
		else if (!ctrl.run)
		begin
			half_cnt <= 3'd0;
			bit_cnt <= 5'd0;
			sck_q <= 1'b0; // SCK idles low in both modes
			done_q <= 1'b0;
		end
		else
		begin
			half_cnt <= (half_cnt == half_max) ? 3'd0 : half_cnt + 3'd1;
			if (tick)
				sck_q <= !sck_q;
			if (fall_tick)
				bit_cnt <= bit_cnt + 5'd1;
			done_q <= fall_tick && (bit_cnt == bit_max); // a single clock wide
		end
	end

	assign ctrl.sck = sck_q;
	assign ctrl.sck_rise = rise_tick;
	assign ctrl.sck_fall = fall_tick;
	assign ctrl.shift_done = done_q;

endmodule

// ==== src/spi_ctrl_if.sv ====
`timescale 1ns/100ps

interface spi_ctrl_if;

	import adc_spi_pkg::*;

	logic run; // high for the whole SHIFT state
	spi_mode_e mode; // mode latched at start
	logic load; // first LEAD clock
	logic capture; // DONE clock
	logic sck;
	logic sck_rise; // sck goes high at the end of this clock
	logic sck_fall; // sck goes low at the end of this clock
	logic shift_done; // one clock after the final falling edge

	modport seq (output run, mode, load, capture, input shift_done);

	modport timer (input run, mode, output sck, sck_rise, sck_fall, shift_done);

	modport rx (input mode, sck_rise, capture);

	modport tx (input mode, load, sck_rise, capture);

endinterface

// ==== src/spi_sequencer.sv ====
`timescale 1ns/100ps

`include "adc_spi_defs.svh"

module spi_sequencer (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	input  adc_spi_pkg::spi_mode_e i_mode,
	output logic o_busy,
	output logic o_cs_n,
	spi_ctrl_if.seq ctrl
);

	import adc_spi_pkg::*;

	seq_state_e state;
	seq_state_e state_nxt;
	logic [3:0] dly_cnt; // shared by LEAD and LAG
	spi_mode_e mode_q;

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
			begin
				if (i_start)
					state_nxt = LEAD;
			end
			LEAD:
			begin
				if (dly_cnt == 4'(`CS_LEAD - 1))
					state_nxt = SHIFT;
			end
			SHIFT:
			begin
				if (ctrl.shift_done)
					state_nxt = LAG;
			end
			LAG:
			begin
				if (dly_cnt == 4'(`CS_LAG - 1))
					state_nxt = DONE;
			end
			DONE:
				state_nxt = IDLE; // no start release needed, the start is a pulse
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			state <= IDLE;
			dly_cnt <= 4'd0;
			mode_q <= MODE_READ;
		end
		else
		begin
			state <= state_nxt;
			if (state_nxt != state)
				dly_cnt <= 4'd0; // every state starts counting from zero
			else if ((state == LEAD) || (state == LAG))
				dly_cnt <= dly_cnt + 4'd1;
			if ((state == IDLE) && i_start)
				mode_q <= i_mode;
		end
	end

	assign ctrl.load = (state == LEAD) && (dly_cnt == 4'd0);
	assign ctrl.run = (state == SHIFT);
	assign ctrl.capture = (state == DONE);
	assign ctrl.mode = mode_q;

	assign o_busy = i_start || (state != IDLE); // covers the start clock as well
	assign o_cs_n = !((state == LEAD) || (state == SHIFT) || (state == LAG));

endmodule

// ==== verification/adc4630_bfm.sv ====
`timescale 1ns/100ps

`include "adc_spi_defs.svh"

module adc4630_bfm (
	input  logic i_cs_n,
	input  logic i_sck,
	input  logic i_mosi,
	input  adc_spi_pkg::sample_t i_sample,
	output logic [`ADC_LANES-1:0] o_miso,
	output adc_spi_pkg::cfg_word_t o_cfg_word,
	output logic [7:0] o_rise_count,
	output logic [15:0] o_frame_count
);

	import adc_spi_pkg::*;

	sample_t sample_q; // held for the whole frame
	cfg_word_t mosi_sr;
	int bit_idx;
	int rises;
	logic in_frame; // ignores the X to 1 step of chip select at reset

	// lane k carries bits 6k+5 down to 6k, msb first
	function automatic logic [`ADC_LANES-1:0] lane_bits(input sample_t smp, input int idx);
		logic [`ADC_LANES-1:0] bits;
		for (int k = 0; k < `ADC_LANES; k++)
			bits[k] = (idx < `LANE_BITS) ? smp[k * `LANE_BITS + `LANE_BITS - 1 - idx] : 1'b0;
		return bits;
	endfunction

	initial
	begin
		o_miso = '0;
		o_cfg_word = '0;
		o_rise_count = '0;
		o_frame_count = '0;
		in_frame = 1'b0;
		bit_idx = 0;
		rises = 0;
	end

	always @(negedge i_cs_n)
	begin
		in_frame = 1'b1;
		sample_q = i_sample;
		bit_idx = 0;
		rises = 0;
		mosi_sr = '0;
		o_miso = lane_bits(i_sample, 0); // mode 00 shows the first bit at chip select
	end

	always @(posedge i_sck)
	begin
		if (in_frame)
			rises++;
	end

	// lanes advance and MOSI is taken on the falling edge
	always @(negedge i_sck)
	begin
		if (in_frame)
		begin
			mosi_sr = {mosi_sr[`CFG_BITS-2:0], i_mosi};
			bit_idx++;
			o_miso = lane_bits(sample_q, bit_idx);
		end
	end

	always @(posedge i_cs_n)
	begin
		if (in_frame)
		begin
			o_cfg_word = mosi_sr;
			o_rise_count = 8'(rises);
			o_frame_count = o_frame_count + 16'd1;
			in_frame = 1'b0;
		end
	end

endmodule

// ==== verification/tb_adc_spi.sv ====
`timescale 1ns/100ps

`include "adc_spi_defs.svh"

module tb_adc_spi;

	import adc_spi_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_CFG = 40;
	localparam int NUM_READ = 40;
	localparam int NUM_FRAMES = NUM_CFG + NUM_READ + 3;
	// a config frame is the longest, counted with one spare bit and the DONE clock
	localparam int FRAME_CLKS = `CS_LEAD + 2 * `CFG_HALF * (`CFG_BITS + 1) + `CS_LAG + 2;
	localparam int WATCHDOG_NS = 2 * (NUM_FRAMES + 2) * (FRAME_CLKS + 32) * CLK_PERIOD;

	logic i_clk;
	logic i_rst;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [2:0] i_wb_adr;
	logic [31:0] i_wb_dat;
	logic [31:0] o_wb_dat;
	logic o_wb_ack;
	logic o_cs_n;
	logic o_sck;
	logic o_mosi;
	logic o_mosi_oe;
	logic [`ADC_LANES-1:0] miso;

	sample_t bfm_sample;
	cfg_word_t bfm_cfg;
	logic [7:0] bfm_rises;
	logic [15:0] bfm_frames;

	logic [31:0] rng_state;
	sample_t model_samples[$]; // captured and not yet read, at most one survives
	logic model_overrun;
	int model_count;
	logic monitor_on;
	logic oe_seen; // MOSI enable seen in the current frame
	logic cs_n_prev;

	adc_spi_top u_dut (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.o_cs_n(o_cs_n),
		.o_sck(o_sck),
		.o_mosi(o_mosi),
		.o_mosi_oe(o_mosi_oe),
		.i_miso(miso)
	);

	adc4630_bfm u_adc (
		.i_cs_n(o_cs_n),
		.i_sck(o_sck),
		.i_mosi(o_mosi),
		.i_sample(bfm_sample),
		.o_miso(miso),
		.o_cfg_word(bfm_cfg),
		.o_rise_count(bfm_rises),
		.o_frame_count(bfm_frames)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// busy is low whenever the model is asked
	function automatic logic [31:0] model_status();
		return {29'd0, model_overrun, model_samples.size() != 0, 1'b0};
	endfunction

	task automatic stop_on_error();
		$display("Testbench failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL %t: %s is %h, expected %h", $realtime, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL %t: %s is %h, expected %h", $realtime, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_cfg(input cfg_word_t got, input cfg_word_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL %t: %s is %h, expected %h", $realtime, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [31:0] dat);
		@(posedge i_clk);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we <= 1'b1;
		i_wb_adr <= adr;
		i_wb_dat <= dat;
		do
			@(posedge i_clk);
		while (o_wb_ack !== 1'b1);
		i_wb_cyc <= 1'b0;
		i_wb_stb <= 1'b0;
		i_wb_we <= 1'b0;
	endtask

	task automatic read_reg(input logic [2:0] adr, output logic [31:0] dat);
		@(posedge i_clk);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we <= 1'b0;
		i_wb_adr <= adr;
		do
			@(posedge i_clk);
		while (o_wb_ack !== 1'b1);
		dat = o_wb_dat;
		i_wb_cyc <= 1'b0;
		i_wb_stb <= 1'b0;
	endtask

	task automatic wait_idle(output logic [31:0] status);
		do
			read_reg(`REG_STATUS, status);
		while (status[0] !== 1'b0);
	endtask

	task automatic load_sample(input sample_t smp);
		@(posedge i_clk);
		bfm_sample <= smp;
	endtask

	task automatic read_sample();
		logic [31:0] data;
		sample_t exp;
		exp = model_samples.pop_front();
		read_reg(`REG_SAMPLE, data);
		compare_sample(sample_t'(data), exp, "SAMPLE register");
		compare_word(data >> 24, 32'd0, "SAMPLE upper bits");
	endtask

	// starts one frame, with optional extra starts written while it runs
	task automatic run_frame(input spi_mode_e mode, input int extra_starts,
		output logic [31:0] status);
		logic [15:0] frames_before;
		int exp_rises;
		frames_before = bfm_frames;
		oe_seen = 1'b0;
		write_reg(`REG_CTRL, (mode == MODE_CFG) ? 32'd2 : 32'd1);
		for (int i = 0; i < extra_starts; i++)
			write_reg(`REG_CTRL, 32'd3);
		wait_idle(status);
		exp_rises = (mode == MODE_CFG) ? `CFG_BITS : `LANE_BITS;
		if (mode == MODE_READ)
		begin
			if (model_samples.size() != 0)
				model_overrun = 1'b1; // the unread sample is lost
			model_samples.delete();
			model_samples.push_back(bfm_sample);
			model_count++;
		end
		compare_word(status, model_status(), "STATUS at end of frame");
		model_overrun = 1'b0; // that STATUS read cleared it
		compare_word(32'(bfm_frames), 32'(frames_before) + 32'd1, "frames seen by the ADC");
		compare_word(32'(bfm_rises), 32'(exp_rises), "SCK rising edges in the frame");
		compare_word({31'd0, oe_seen}, {31'd0, mode == MODE_CFG}, "MOSI enable in the frame");
		compare_word({31'd0, o_cs_n}, 32'd1, "chip select after the frame");
	endtask

	// MOSI enable may trail chip select by the DONE clock and no more
	always @(negedge i_clk)
	begin
		if (monitor_on)
		begin
			if (o_cs_n === 1'b1 && o_sck !== 1'b0)
			begin
				$display("SCK left low level while chip select was high at %t", $realtime);
				stop_on_error();
			end
			if (o_mosi_oe === 1'b1)
			begin
				oe_seen = 1'b1;
				if (o_cs_n === 1'b1 && cs_n_prev === 1'b1)
				begin
					$display("MOSI output enable was high outside a frame at %t", $realtime);
					stop_on_error();
				end
			end
			cs_n_prev = o_cs_n;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
		stop_on_error();
	end

	initial
	begin
		logic [31:0] data;
		logic [31:0] status;
		cfg_word_t cfg;
		sample_t smp;
		logic [15:0] frames_before;
		$timeformat(-9, 1, " ns", 0);
		rng_state = 32'h3fd6_1403;
		model_overrun = 1'b0;
		model_count = 0;
		monitor_on = 1'b0;
		oe_seen = 1'b0;
		cs_n_prev = 1'b1;
		bfm_sample = '0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = 3'd0;
		i_wb_dat = 32'd0;
		i_rst = 1'b0;
		repeat (4) @(posedge i_clk);
		i_rst <= 1'b1;
		@(posedge i_clk);
		monitor_on = 1'b1;

		compare_word({31'd0, o_cs_n}, 32'd1, "chip select after reset");
		compare_word({31'd0, o_sck}, 32'd0, "SCK after reset");
		compare_word({31'd0, o_mosi_oe}, 32'd0, "MOSI enable after reset");
		read_reg(`REG_STATUS, data);
		compare_word(data, 32'd0, "STATUS after reset");
		read_reg(`REG_COUNT, data);
		compare_word(data, 32'd0, "COUNT after reset");

		for (int i = 0; i < NUM_CFG; i++)
		begin
			data = next_random();
			cfg = cfg_word_t'(data); // only the low 24 bits are kept
			write_reg(`REG_CFG, data);
			read_reg(`REG_CFG, data);
			compare_word(data, 32'(cfg), "CFG readback");
			run_frame(MODE_CFG, 0, status);
			compare_cfg(bfm_cfg, cfg, "config word at the ADC");
		end

		for (int i = 0; i < NUM_READ; i++)
		begin
			smp = sample_t'(next_random());
			load_sample(smp);
			run_frame(MODE_READ, 0, status);
			read_sample();
		end

		// two samples in a row with no SAMPLE read in between
		load_sample(sample_t'(next_random()));
		run_frame(MODE_READ, 0, status);
		load_sample(sample_t'(next_random()));
		run_frame(MODE_READ, 0, status);
		compare_word(status & 32'h4, 32'h4, "overrun after an unread sample");
		read_reg(`REG_STATUS, data);
		compare_word(data, model_status(), "STATUS after overrun was read");
		read_sample();
		read_reg(`REG_STATUS, data);
		compare_word(data, model_status(), "STATUS after SAMPLE was read");

		smp = sample_t'(next_random());
		load_sample(smp);
		run_frame(MODE_READ, 2, status);
		frames_before = bfm_frames;
		repeat (FRAME_CLKS) @(posedge i_clk); // an accepted extra start would show up here
		compare_word(32'(bfm_frames), 32'(frames_before), "frames after starts while busy");
		compare_word({31'd0, o_cs_n}, 32'd1, "chip select while idle");
		read_sample();
		read_reg(`REG_COUNT, data);
		compare_word(data, 32'(model_count), "COUNT of read frames");

		$display("Testbench passed");
		$finish;
	end

endmodule
